//--- all.f
+incdir+testbench
hdl/riscv_ex_pkg.sv
hdl/riscv_alu.sv
hdl/riscv_mult.sv
hdl/riscv_ex_pipeline.sv
hdl/riscv_ex_top.sv
testbench/riscv_ex_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module riscv_ex_tb -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vriscv_ex_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

//--- testbench/riscv_ex_model.svh
/*
 * Reference model of the EX stage
 * Expected result of one request, worked out from the opcode rules
 */
`ifndef RISCV_EX_MODEL_SVH
`define RISCV_EX_MODEL_SVH

// Halfword pick, widened to 64 bits with sign or zero fill
function automatic longint extend_half(input logic [31:0] word, input logic upper,
                                       input logic sgn);
  logic [15:0] half;
  half = upper ? word[31:16] : word[15:0];
  if (sgn)
    return longint'($signed(half));
  else
    return longint'({48'h0, half});
endfunction

// Result word expected for a request
function automatic logic [31:0] expected_result(input ex_req_t req);
  logic [63:0] prod;
  logic [31:0] acc;
  longint      va;
  longint      vb;
  // Accumulator only joins for the MAC flavours
  acc  = (req.op == OP_MAC || req.op == OP_VMAC) ? req.op_c : 32'h0;
  va   = extend_half(req.op_a, req.sel_subword[1], req.signed_mode[1]);
  vb   = extend_half(req.op_b, req.sel_subword[0], req.signed_mode[0]);
  prod = {32'h0, req.op_a} * {32'h0, req.op_b};
  case (req.op)
    OP_ADD:  return req.op_a + req.op_b;
    OP_SUB:  return req.op_a - req.op_b;
    OP_AND:  return req.op_a & req.op_b;
    OP_OR:   return req.op_a | req.op_b;
    OP_XOR:  return req.op_a ^ req.op_b;
    OP_SLL:  return req.op_a << req.op_b[4:0];
    OP_SRL:  return req.op_a >> req.op_b[4:0];
    OP_SLT:  return ($signed(req.op_a) < $signed(req.op_b)) ? 32'd1 : 32'd0;
    // Low word of the full product
    OP_MUL, OP_MAC: return prod[31:0] + acc;
    OP_VMUL, OP_VMAC:
    begin
      prod = 64'(va * vb);
      return prod[31:0] + acc;
    end
    default: return 32'h0;
  endcase
endfunction

`endif

//--- testbench/riscv_ex_tb.sv
/*
 * Testbench of the EX stage
 * Drives requests through the handshake and checks every response in order
 */
`default_nettype none

module riscv_ex_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import riscv_ex_pkg::*;

  `include "riscv_ex_model.svh"

  // Wait limit in cycles
  localparam int LIMIT = 200;

  logic     clk;
  logic     arst_n;
  logic     req_valid;
  ex_req_t  req;
  logic     req_ready;
  logic     resp_valid;
  ex_resp_t resp;
  logic     resp_ready = 1'b1;

  // Phase controls
  logic     stall_en = 1'b0;
  logic     check_latency = 1'b0;
  string    test_name = "reset";

  // Expected responses and their accept cycles
  ex_resp_t exp_q[$];
  int       lat_q[$];
  int       cycles = 0;
  int       seed = 32'hcf99;
  int       ready_seed = 32'hcf99;

  riscv_ex_top #(.VECTOR_EN(1)) i_riscv_ex_top
  (
    .clk          ( clk        ),
    .arst_n_i     ( arst_n     ),
    .req_valid_i  ( req_valid  ),
    .req_i        ( req        ),
    .req_ready_o  ( req_ready  ),
    .resp_valid_o ( resp_valid ),
    .resp_o       ( resp       ),
    .resp_ready_i ( resp_ready )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  function automatic ex_req_t random_req(input ex_op_e op);
    ex_req_t r;
    r.op          = op;
    r.op_a        = $random(seed);
    r.op_b        = $random(seed);
    r.op_c        = $random(seed);
    r.sel_subword = 2'($random(seed));
    r.signed_mode = 2'($random(seed));
    return r;
  endfunction

  // Hold the request until the DUT takes it
  task automatic send(input ex_req_t r);
    int waited;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    do
    begin
      @(posedge clk);
      waited++;
      if (waited > LIMIT)
        stop_run("request was never accepted");
    end
    while (!req_ready);
    #2;
    req_valid = 1'b0;
  endtask

  // Wait until every expected response is out
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > LIMIT)
        stop_run("responses did not drain");
    end
  endtask

  //////////////////////////////
  // Checking
  //////////////////////////////

  // Random back-pressure when enabled
  always @(posedge clk)
  begin
    #2;
    resp_ready = stall_en ? 1'($random(ready_seed)) : 1'b1;
  end

  // Held response must not move
  assert property (@(posedge clk) disable iff (!arst_n)
                   (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
    else stop_run("response changed while the output was stalled");

  always @(posedge clk)
  begin
    ex_resp_t want;
    ex_resp_t head;
    int       sent_at;
    if (arst_n)
    begin
      if (req_valid && req_ready)
      begin
        want.result = expected_result(req);
        want.op     = req.op;
        exp_q.push_back(want);
        lat_q.push_back(cycles);
      end
      if (resp_valid && resp_ready)
      begin
        if (exp_q.size() == 0)
          stop_run("a response arrived with no request outstanding");
        else
        begin
          head    = exp_q.pop_front();
          sent_at = lat_q.pop_front();
          assert (resp == head)
            else stop_run($sformatf("[FAIL] %s: expected %h, actual %h",
                                    test_name, head, resp));
          // Unstalled path is two edges deep
          if (check_latency)
            assert (cycles - sent_at == 2)
              else stop_run($sformatf("[FAIL] %s latency: expected 2, actual %0d",
                                      test_name, cycles - sent_at));
        end
      end
    end
    cycles++;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    ex_req_t r;
    int      i;
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // Output idle out of reset
    repeat (2)
    begin
      @(posedge clk);
      assert (!resp_valid)
        else stop_run($sformatf("[FAIL] reset: expected 0, actual %b", resp_valid));
    end
    #2;

    // Every ALU op with ready held high
    test_name     = "alu";
    check_latency = 1'b1;
    for (i = 0; i < 32; i++)
      send(random_req(ex_op_e'(4'(i % 8))));
    drain();

    test_name = "mul";
    for (i = 0; i < 16; i++)
      send(random_req(i[0] ? OP_MAC : OP_MUL));
    drain();

    // All selects and modes with halfword sign bits set
    test_name = "vector";
    for (i = 0; i < 32; i++)
    begin
      r              = random_req(i[4] ? OP_VMAC : OP_VMUL);
      r.op_a         = r.op_a | 32'h80008000;
      r.op_b         = r.op_b | 32'h80008000;
      r.sel_subword  = i[3:2];
      r.signed_mode  = i[1:0];
      send(r);
    end
    drain();

    // Back-to-back mix under random stalls
    test_name     = "stall";
    check_latency = 1'b0;
    stall_en      = 1'b1;
    for (i = 0; i < 48; i++)
      send(random_req(ex_op_e'(4'($unsigned($random(seed)) % 12))));
    drain();
    stall_en = 1'b0;

    // Idle tail where any stray response hits the checker
    repeat (4) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/riscv_ex_top.sv
/*
 * EX stage top level
 * Sets the vector enable and wraps the pipeline
 */
`default_nettype none

module riscv_ex_top
#(
  // 0 turns vector opcodes into plain multiply and MAC
  parameter int unsigned VECTOR_EN = 1
)
(
  input  logic                   clk,
  input  logic                   arst_n_i,

  // Request side
  input  logic                   req_valid_i,
  input  riscv_ex_pkg::ex_req_t  req_i,
  output logic                   req_ready_o,

  // Response side
  output logic                   resp_valid_o,
  output riscv_ex_pkg::ex_resp_t resp_o,
  input  logic                   resp_ready_i
);

  riscv_ex_pipeline
  #(
    .VECTOR_EN ( VECTOR_EN )
  )
  i_riscv_ex_pipeline
  (
    .clk          ( clk          ),
    .arst_n_i     ( arst_n_i     ),
    .req_valid_i  ( req_valid_i  ),
    .req_i        ( req_i        ),
    .req_ready_o  ( req_ready_o  ),
    .resp_valid_o ( resp_valid_o ),
    .resp_o       ( resp_o       ),
    .resp_ready_i ( resp_ready_i )
  );

endmodule

`default_nettype wire

//--- hdl/riscv_ex_pipeline.sv
/*
 * EX stage pipeline
 * Two registered stages with valid/ready on both sides, ALU and MAC between
 */
`default_nettype none

module riscv_ex_pipeline
#(
  parameter int unsigned VECTOR_EN = 1
)
(
  input  logic                   clk,
  input  logic                   arst_n_i,

  input  logic                   req_valid_i,
  input  riscv_ex_pkg::ex_req_t  req_i,
  output logic                   req_ready_o,

  output logic                   resp_valid_o,
  output riscv_ex_pkg::ex_resp_t resp_o,
  input  logic                   resp_ready_i
);

  import riscv_ex_pkg::*;

  // Stage registers and their valid bits
  logic              s0_valid;
  ex_req_t           s0_req;
  logic              s1_valid;
  ex_resp_t          s1_resp;

  // Both stages move on the same enable
  logic              advance;

  // Decoded unit controls
  alu_op_e           alu_op;
  logic              use_mult;
  logic              mac_en;
  logic              vector_mode;

  // Unit outputs and the selected response
  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] mult_result;
  ex_resp_t          s0_resp;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Stall only when stage 1 holds data the sink refuses
  assign advance     = ~s1_valid | resp_ready_i;
  assign req_ready_o = advance;

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      s0_valid <= 1'b0;
      s1_valid <= 1'b0;
    end
    else if (advance)
    begin
      // A bubble in stage 0 moves on as invalid
      s0_valid <= req_valid_i;
      s1_valid <= s0_valid;
    end
  end

  // Payload registers follow the same enable
  always_ff @(posedge clk)
  begin
    if (advance)
    begin
      s0_req  <= req_i;
      s1_resp <= s0_resp;
    end
  end

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb
  begin
    alu_op      = ALU_ADD;
    use_mult    = 1'b0;
    mac_en      = 1'b0;
    vector_mode = 1'b0;

    case (s0_req.op)
      OP_ADD:  alu_op = ALU_ADD;
      OP_SUB:  alu_op = ALU_SUB;
      OP_AND:  alu_op = ALU_AND;
      OP_OR:   alu_op = ALU_OR;
      OP_XOR:  alu_op = ALU_XOR;
      OP_SLL:  alu_op = ALU_SLL;
      OP_SRL:  alu_op = ALU_SRL;
      OP_SLT:  alu_op = ALU_SLT;
      OP_MUL:  use_mult = 1'b1;
      OP_MAC:
      begin
        use_mult = 1'b1;
        mac_en   = 1'b1;
      end
      // Vector ops fall back to plain ones without the vector path
      OP_VMUL:
      begin
        use_mult    = 1'b1;
        vector_mode = (VECTOR_EN != 0);
      end
      OP_VMAC:
      begin
        use_mult    = 1'b1;
        mac_en      = 1'b1;
        vector_mode = (VECTOR_EN != 0);
      end
      default: alu_op = ALU_ADD;
    endcase
  end

  //////////////////////////////
  // Function units
  //////////////////////////////

  riscv_alu i_alu
  (
    .operator_i  ( alu_op       ),
    .operand_a_i ( s0_req.op_a  ),
    .operand_b_i ( s0_req.op_b  ),
    .result_o    ( alu_result   )
  );

  riscv_mult i_mult
  (
    .mac_en_i      ( mac_en             ),
    .vector_mode_i ( vector_mode        ),
    .sel_subword_i ( s0_req.sel_subword ),
    .signed_mode_i ( s0_req.signed_mode ),
    .op_a_i        ( s0_req.op_a        ),
    .op_b_i        ( s0_req.op_b        ),
    .mac_i         ( s0_req.op_c        ),
    .result_o      ( mult_result        )
  );

  // Result by opcode class, opcode echoed
  assign s0_resp.result = use_mult ? mult_result : alu_result;
  assign s0_resp.op     = s0_req.op;

  // Output side straight from stage 1
  assign resp_valid_o = s1_valid;
  assign resp_o       = s1_resp;

endmodule

`default_nettype wire

//--- hdl/riscv_mult.sv
/*
 * Multiplier and MAC
 * 32-bit multiply or multiply-accumulate, with halfword select and extension
 */
`default_nettype none

module riscv_mult
(
  input  logic                             mac_en_i,
  input  logic                             vector_mode_i,
  input  logic [1:0]                       sel_subword_i,
  input  logic [1:0]                       signed_mode_i,

  input  logic [riscv_ex_pkg::DATA_W-1:0]  op_a_i,
  input  logic [riscv_ex_pkg::DATA_W-1:0]  op_b_i,
  input  logic [riscv_ex_pkg::DATA_W-1:0]  mac_i,

  output logic [riscv_ex_pkg::DATA_W-1:0]  result_o
);

  import riscv_ex_pkg::*;

  // Operands after subword selection
  logic [HALF_W-1:0] half_a;
  logic [HALF_W-1:0] half_b;
  logic [DATA_W-1:0] mul_a;
  logic [DATA_W-1:0] mul_b;
  // Accumulator term, zero unless MAC
  logic [DATA_W-1:0] acc;

  // Halfword pick, 1 selects the upper half
  assign half_a = sel_subword_i[1] ? op_a_i[DATA_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign half_b = sel_subword_i[0] ? op_b_i[DATA_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  // Vector mode replaces each operand by its extended halfword
  always_comb
  begin
    mul_a = op_a_i;
    mul_b = op_b_i;

    if (vector_mode_i)
    begin
      // Sign bit only counts when signed mode is set
      mul_a = {{HALF_W{signed_mode_i[1] & half_a[HALF_W-1]}}, half_a};
      mul_b = {{HALF_W{signed_mode_i[0] & half_b[HALF_W-1]}}, half_b};
    end
  end

  assign acc = mac_en_i ? mac_i : '0;

  // Only the low word of the product is kept
  assign result_o = acc + mul_a * mul_b;

endmodule

`default_nettype wire

//--- hdl/riscv_alu.sv
/*
 * Integer ALU
 * Add, sub, logic ops, shifts and signed set-less-than, purely combinational
 */
`default_nettype none

module riscv_alu
(
  input  riscv_ex_pkg::alu_op_e                operator_i,
  input  logic [riscv_ex_pkg::DATA_W-1:0]      operand_a_i,
  input  logic [riscv_ex_pkg::DATA_W-1:0]      operand_b_i,
  output logic [riscv_ex_pkg::DATA_W-1:0]      result_o
);

  import riscv_ex_pkg::*;

  // Shift amount comes from the low bits of b only
  logic [4:0]        shamt;
  // Shared adder results
  logic [DATA_W-1:0] sum;
  logic [DATA_W-1:0] diff;
  // Signed compare flag
  logic              a_lt_b;

  //////////////////////////////
  // Arithmetic
  //////////////////////////////

  assign shamt = operand_b_i[4:0];
  assign sum   = operand_a_i + operand_b_i;
  assign diff  = operand_a_i - operand_b_i;

  // Set-less-than treats both operands as two's complement
  assign a_lt_b = ($signed(operand_a_i) < $signed(operand_b_i));

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb
  begin
    result_o = '0;

    case (operator_i)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;

      // Bitwise logic
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      // Logical shifts, zero fill
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;

      // Yields 1 or 0 in the lowest bit
      ALU_SLT: result_o = {{(DATA_W-1){1'b0}}, a_lt_b};

      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/riscv_ex_pkg.sv
/*
 * Shared types of the EX stage
 * Opcode and ALU operation encodings, request and response words
 */
`default_nettype none

package riscv_ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Operand and result width
  localparam int unsigned DATA_W = 32;
  // One halfword, used by the vector multiply path
  localparam int unsigned HALF_W = DATA_W / 2;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Request opcode as seen at the EX input
  typedef enum logic [3:0] {
    // Integer ALU class
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    OP_SLT  = 4'h7,
    // Multiplier class
    OP_MUL  = 4'h8,
    OP_MAC  = 4'h9,
    OP_VMUL = 4'hA,
    OP_VMAC = 4'hB
  } ex_op_e;

  // Operation select of the integer ALU
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  //////////////////////////////
  // Handshake payloads
  //////////////////////////////

  // Request word, c is the accumulator input for MAC ops
  typedef struct packed {
    ex_op_e            op;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] op_c;
    // Bit 1 picks the halfword of a, bit 0 that of b
    logic [1:0]        sel_subword;
    // Bit 1 sign-extends a, bit 0 sign-extends b
    logic [1:0]        signed_mode;
  } ex_req_t;

  // Response word, opcode echoed for tracing
  typedef struct packed {
    logic [DATA_W-1:0] result;
    ex_op_e            op;
  } ex_resp_t;

endpackage

`default_nettype wire
